// ==== src/refcpu_pkg.sv ====
package refcpu_pkg;

    // instruction layout
    // [31:28] opcode, [27:25] rd, [24:22] rs, [21:19] rt, [15:0] imm
    // imm is sign-extended for addi, lw and sw

    // core states, one stage module per state
    typedef enum logic [2:0] {
        st_fetch   = 3'd0,
        st_decode  = 3'd1,
        st_exec    = 3'd2,
        st_mem     = 3'd3,
        st_commit  = 3'd4,
        st_halted  = 3'd5,
        st_unknown = 3'd6
    } state_t;

    // highest valid state, anything above traps
    localparam state_t last_state = st_unknown;

    // opcodes, codes 10 to 15 are undefined
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_addi = 4'd6,
        op_lw   = 4'd7,
        op_sw   = 4'd8,
        op_halt = 4'd9
    } opcode_t;

    // instruction bus, valid held until data_ok
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } ibus_req_t;

    typedef struct packed {
        logic        data_ok;
        logic [31:0] data;
    } ibus_resp_t;

    // data bus, same handshake for reads and writes
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dbus_req_t;

    typedef struct packed {
        logic        data_ok;
        logic [31:0] data;
    } dbus_resp_t;

    // eight registers, entry zero never written
    typedef logic [7:0][31:0] regfile_t;

    // whole architectural and in-flight state of the core
    typedef struct packed {
        state_t      state;
        logic [31:0] pc;
        logic [31:0] instr;
        opcode_t     op;
        logic [2:0]  rd;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] imm;
        logic [31:0] result;
        regfile_t    regs;
    } context_t;

    // clean context that starts fetching at reset_pc
    function automatic context_t reset_context(logic [31:0] reset_pc);
        context_t c;
        c = '0;
        c.state = st_fetch;
        c.pc = reset_pc;
        return c;
    endfunction

endpackage

// ==== src/fetch.sv ====
`timescale 1ns/1ns

module fetch (
    input  logic                   clk,
    input  refcpu_pkg::context_t   ctx,
    input  refcpu_pkg::ibus_resp_t iresp,
    output refcpu_pkg::context_t   out,
    output refcpu_pkg::ibus_req_t  ireq
);
    import refcpu_pkg::*;

    // read at pc for as long as the core sits in fetch
    always_comb begin
        ireq.valid = (ctx.state == st_fetch);
        ireq.addr = ctx.pc;
    end

    // wait here until the word comes back
    always_comb begin
        out = ctx;
        if (iresp.data_ok) begin
            out.instr = iresp.data;
            out.state = st_decode;
        end
    end

    // address must not move while the request is pending
    property p_addr_stable;
        @(posedge clk) ireq.valid && !iresp.data_ok |=> ireq.valid && $stable(ireq.addr);
    endproperty

    a_addr_stable: assert property (p_addr_stable)
        else $error("fetch address changed while waiting for data_ok");

endmodule

// ==== src/decode.sv ====
`timescale 1ns/1ns

module decode (
    input  refcpu_pkg::context_t ctx,
    output refcpu_pkg::context_t out
);
    import refcpu_pkg::*;

    opcode_t     op;
    logic [2:0]  rs_idx;
    logic [2:0]  rt_idx;

    // field split
    assign op = opcode_t'(ctx.instr[31:28]);
    assign rs_idx = ctx.instr[24:22];
    assign rt_idx = ctx.instr[21:19];

    always_comb begin
        out = ctx;
        out.op = op;
        out.rd = ctx.instr[27:25];
        // register zero reads as zero
        out.rs_val = (rs_idx == 3'd0) ? 32'd0 : ctx.regs[rs_idx];
        out.rt_val = (rt_idx == 3'd0) ? 32'd0 : ctx.regs[rt_idx];
        out.imm = {{16{ctx.instr[15]}}, ctx.instr[15:0]};
        out.result = '0;

        // pick the path
        case (op)
            op_nop, op_add, op_sub, op_and, op_or, op_xor, op_addi: begin
                out.state = st_exec;
            end
            op_lw, op_sw: begin
                out.state = st_mem;
            end
            op_halt: begin
                out.state = st_halted;
            end
            // undefined opcode traps
            default: begin
                out.state = st_unknown;
            end
        endcase
    end

endmodule

// ==== src/execute.sv ====
`timescale 1ns/1ns

module execute (
    input  refcpu_pkg::context_t ctx,
    output refcpu_pkg::context_t out
);
    import refcpu_pkg::*;

    logic        alu_op;
    logic [31:0] alu_result;

    // ops that decode routes down this path
    assign alu_op = ctx.op inside {op_nop, op_add, op_sub, op_and, op_or, op_xor, op_addi};

    always_comb begin
        case (ctx.op)
            op_add:  alu_result = ctx.rs_val + ctx.rt_val;
            op_sub:  alu_result = ctx.rs_val - ctx.rt_val;
            op_and:  alu_result = ctx.rs_val & ctx.rt_val;
            op_or:   alu_result = ctx.rs_val | ctx.rt_val;
            op_xor:  alu_result = ctx.rs_val ^ ctx.rt_val;
            // immediate form uses the sign-extended imm
            op_addi: alu_result = ctx.rs_val + ctx.imm;
            // nop lands here, commit drops it
            default: alu_result = '0;
        endcase
    end

    // single cycle, straight on to commit
    always_comb begin
        out = ctx;
        out.result = alu_result;
        out.state = st_commit;
    end

    // decode must never send a memory, halt or bad opcode here
    always_comb begin
        if (ctx.state == st_exec) begin
            a_alu_only: assert #0 (alu_op)
                else $error("execute selected with non-ALU opcode %0d", ctx.op);
        end
    end

endmodule

// ==== src/mem_access.sv ====
`timescale 1ns/1ns

module mem_access (
    input  logic                   clk,
    input  refcpu_pkg::context_t   ctx,
    input  refcpu_pkg::dbus_resp_t dresp,
    output refcpu_pkg::context_t   out,
    output refcpu_pkg::dbus_req_t  dreq
);
    import refcpu_pkg::*;

    logic [31:0] eff_addr;

    // base plus offset, imm may be negative
    assign eff_addr = ctx.rs_val + ctx.imm;

    // request held while the core sits in mem
    always_comb begin
        dreq.valid = (ctx.state == st_mem);
        dreq.write = (ctx.op == op_sw);
        dreq.addr = eff_addr;
        // store data comes from rt
        dreq.wdata = ctx.rt_val;
    end

    always_comb begin
        out = ctx;
        if (dresp.data_ok) begin
            // load data, ignored by commit for stores
            out.result = dresp.data;
            out.state = st_commit;
        end
    end

    // nothing in the request may change before data_ok
    property p_req_stable;
        @(posedge clk) dreq.valid && !dresp.data_ok |=> dreq.valid && $stable(dreq);
    endproperty

    a_req_stable: assert property (p_req_stable)
        else $error("data request changed while waiting for data_ok");

endmodule

// ==== src/commit.sv ====
`timescale 1ns/1ns

module commit (
    input  refcpu_pkg::context_t ctx,
    output refcpu_pkg::context_t out
);
    import refcpu_pkg::*;

    logic wr_en;

    // stores and nops leave the register file alone
    // register zero stays zero
    assign wr_en = (ctx.op != op_sw) && (ctx.op != op_nop) && (ctx.rd != 3'd0);

    always_comb begin
        out = ctx;
        if (wr_en) begin
            out.regs[ctx.rd] = ctx.result;
        end
        // no branches, always the next word
        out.pc = ctx.pc + 32'd4;
        out.state = st_fetch;
    end

endmodule

// ==== src/refcpu.sv ====
`timescale 1ns/1ns

module refcpu #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic                   clk,
    input  logic                   resetn,
    output refcpu_pkg::ibus_req_t  ireq,
    input  refcpu_pkg::ibus_resp_t iresp,
    output refcpu_pkg::dbus_req_t  dreq,
    input  refcpu_pkg::dbus_resp_t dresp
);
    import refcpu_pkg::*;

    // live context and its copy taken at each commit for debug
    context_t ctx;
    context_t checkpoint;
    context_t new_ctx;

    // per-state proposals and bus requests
    context_t  [last_state:0] out_ctx;
    ibus_req_t [last_state:0] out_ireq;
    dbus_req_t [last_state:0] out_dreq;

    ibus_req_t sel_ireq;
    dbus_req_t sel_dreq;

    fetch fetch_inst (
        .clk   (clk),
        .ctx   (ctx),
        .iresp (iresp),
        .out   (out_ctx[st_fetch]),
        .ireq  (out_ireq[st_fetch])
    );

    decode decode_inst (
        .ctx (ctx),
        .out (out_ctx[st_decode])
    );

    execute execute_inst (
        .ctx (ctx),
        .out (out_ctx[st_exec])
    );

    mem_access mem_access_inst (
        .clk   (clk),
        .ctx   (ctx),
        .dresp (dresp),
        .out   (out_ctx[st_mem]),
        .dreq  (out_dreq[st_mem])
    );

    commit commit_inst (
        .ctx (ctx),
        .out (out_ctx[st_commit])
    );

    // halted and unknown just spin on ctx
    assign out_ctx[st_halted] = ctx;
    assign out_ctx[st_unknown] = ctx;

    // only fetch talks to the ibus and only mem to the dbus
    assign out_ireq[st_decode] = '0;
    assign out_ireq[st_exec] = '0;
    assign out_ireq[st_mem] = '0;
    assign out_ireq[st_commit] = '0;
    assign out_ireq[st_halted] = '0;
    assign out_ireq[st_unknown] = '0;
    assign out_dreq[st_fetch] = '0;
    assign out_dreq[st_decode] = '0;
    assign out_dreq[st_exec] = '0;
    assign out_dreq[st_commit] = '0;
    assign out_dreq[st_halted] = '0;
    assign out_dreq[st_unknown] = '0;

    // dispatch on the current state
    always_comb begin
        if (ctx.state > last_state) begin
            // invalid state traps and goes quiet
            new_ctx = ctx;
            new_ctx.state = st_unknown;
            sel_ireq = '0;
            sel_dreq = '0;
        end else begin
            new_ctx = out_ctx[ctx.state];
            sel_ireq = out_ireq[ctx.state];
            sel_dreq = out_dreq[ctx.state];
            // a stage proposing a bad state also traps
            if (new_ctx.state > last_state) begin
                new_ctx.state = st_unknown;
            end
        end
    end

    // both valids held low for the whole reset
    assign ireq = resetn ? '0 : sel_ireq;
    assign dreq = resetn ? '0 : sel_dreq;

    // resetn is active high
    always_ff @(posedge clk) begin
        if (resetn) begin
            ctx <= reset_context(reset_pc);
            checkpoint <= reset_context(reset_pc);
        end else begin
            ctx <= new_ctx;
            // snapshot after each committed instruction
            if (ctx.state == st_commit) begin
                checkpoint <= new_ctx;
            end
        end
    end

    a_state_valid: assert property (@(posedge clk) disable iff (resetn)
        ctx.state <= last_state)
        else $error("context state %0d out of range", ctx.state);

endmodule

// ==== bench/refcpu_tb.sv ====
`timescale 1ns/1ns

module refcpu_tb;

    // opcode codes as laid out in instruction bits 31 to 28
    localparam logic [3:0] opc_nop  = 4'd0;
    localparam logic [3:0] opc_add  = 4'd1;
    localparam logic [3:0] opc_sub  = 4'd2;
    localparam logic [3:0] opc_and  = 4'd3;
    localparam logic [3:0] opc_or   = 4'd4;
    localparam logic [3:0] opc_xor  = 4'd5;
    localparam logic [3:0] opc_addi = 4'd6;
    localparam logic [3:0] opc_lw   = 4'd7;
    localparam logic [3:0] opc_sw   = 4'd8;
    localparam logic [3:0] opc_halt = 4'd9;

    // instructions fetched over all runs and the number of runs
    localparam int total_instr = 51;
    localparam int num_runs = 6;
    // 40 cycles per instruction plus reset and idle window per run
    localparam int max_cycles = total_instr * 40 + num_runs * 60 + 100;

    logic                   clk;
    logic                   resetn;
    refcpu_pkg::ibus_req_t  ireq;
    refcpu_pkg::ibus_resp_t iresp;
    refcpu_pkg::dbus_req_t  dreq;
    refcpu_pkg::dbus_resp_t dresp;

    // word-addressed memories of 1 KiB each
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    int          prog_len;

    // bus model state
    logic        ipend;
    logic        dpend;
    int          icnt;
    int          dcnt;
    logic [31:0] iword;
    logic [31:0] rng;
    logic        random_delay;
    logic        stop_seen;

    // what the DUT did and what it should have done
    logic [31:0] fetch_addrs [$];
    logic [31:0] store_addr [$];
    logic [31:0] store_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    int errors;
    int cycles;

    refcpu #(
        .reset_pc (32'h0)
    ) refcpu_inst (
        .clk    (clk),
        .resetn (resetn),
        .ireq   (ireq),
        .iresp  (iresp),
        .dreq   (dreq),
        .dresp  (dresp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // background data with every byte tied to the word index
    function automatic logic [31:0] fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a, ~a, a ^ 8'h3c, a + 8'ha5};
    endfunction

    function automatic logic [31:0] instr(input logic [3:0] op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [2:0] rt,
                                          input logic [15:0] imm);
        return {op, rd, rs, rt, 3'b000, imm};
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("[ERROR] %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout: the core did not stop within %0d cycles", max_cycles);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    // memory model driven on the falling edge
    always @(negedge clk) begin
        iresp <= '0;
        dresp <= '0;
        if (resetn) begin
            ipend = 1'b0;
            dpend = 1'b0;
        end else begin
            // instruction side
            if (ireq.valid) begin
                if (!ipend) begin
                    ipend = 1'b1;
                    rng = xorshift32(rng);
                    icnt = random_delay ? rng[1:0] + 1 : 1;
                    fetch_addrs.push_back(ireq.addr);
                end
                icnt = icnt - 1;
                // delay 1 answers in the request cycle
                if (icnt == 0) begin
                    ipend = 1'b0;
                    iword = imem[ireq.addr[9:2]];
                    iresp <= {1'b1, iword};
                    // halt or an undefined opcode ends the program
                    if (iword[31:28] >= opc_halt) begin
                        stop_seen = 1'b1;
                    end
                end
            end
            // data side
            if (dreq.valid) begin
                if (!dpend) begin
                    dpend = 1'b1;
                    rng = xorshift32(rng);
                    dcnt = random_delay ? rng[1:0] + 1 : 1;
                end
                dcnt = dcnt - 1;
                if (dcnt == 0) begin
                    dpend = 1'b0;
                    if (dreq.write) begin
                        dmem[dreq.addr[9:2]] = dreq.wdata;
                        store_addr.push_back(dreq.addr);
                        store_data.push_back(dreq.wdata);
                        dresp <= {1'b1, 32'h0};
                    end else begin
                        dresp <= {1'b1, dmem[dreq.addr[9:2]]};
                    end
                end
            end
        end
    end

    task automatic clear_memories();
        int i;
        for (i = 0; i < 256; i++) begin
            // zero decodes as nop
            imem[i] = 32'h0;
            dmem[i] = fill_word(i);
        end
        prog_len = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len = prog_len + 1;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // five cycles of reset with both valids low throughout
    task automatic apply_reset();
        @(negedge clk);
        resetn <= 1'b1;
        fetch_addrs.delete();
        store_addr.delete();
        store_data.delete();
        stop_seen = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_equal(ireq.valid, 1'b0, "ireq valid during reset");
            check_equal(dreq.valid, 1'b0, "dreq valid during reset");
        end
        resetn <= 1'b0;
    endtask

    task automatic run_program(input logic rand_en, input int n_fetch);
        int i;
        random_delay = rand_en;
        apply_reset();
        while (!stop_seen) begin
            @(posedge clk);
        end
        // core must go quiet after halt or trap
        repeat (50) begin
            @(negedge clk);
            check_equal(ireq.valid, 1'b0, "ireq valid after stop");
            check_equal(dreq.valid, 1'b0, "dreq valid after stop");
        end
        // straight-line code fetches each word once from zero
        check_equal(fetch_addrs.size(), n_fetch, "fetch count");
        for (i = 0; i < fetch_addrs.size(); i++) begin
            check_equal(fetch_addrs[i], 32'h4 * i, "fetch address");
        end
        check_equal(store_addr.size(), exp_addr.size(), "store count");
        for (i = 0; i < store_addr.size(); i++) begin
            check_equal(store_addr[i], exp_addr[i], "store address");
            check_equal(store_data[i], exp_data[i], "store data");
        end
    endtask

    task automatic alu_results(input logic rand_en);
        logic [31:0] vals [8];
        int k;
        clear_memories();
        vals[0] = 32'h0;
        vals[1] = 32'h0000_1234;
        // -3 sign-extended
        vals[2] = 32'hffff_fffd;
        vals[3] = vals[1] + vals[2];
        vals[4] = vals[1] - vals[2];
        vals[5] = vals[1] & vals[2];
        vals[6] = vals[1] | vals[2];
        vals[7] = vals[1] ^ vals[2];
        emit(instr(opc_addi, 3'd1, 3'd0, 3'd0, 16'h1234));
        emit(instr(opc_addi, 3'd2, 3'd0, 3'd0, 16'hfffd));
        emit(instr(opc_add, 3'd3, 3'd1, 3'd2, 16'h0));
        // nop aimed at r3 must leave the sum in place
        emit(instr(opc_nop, 3'd3, 3'd1, 3'd2, 16'h0));
        emit(instr(opc_sub, 3'd4, 3'd1, 3'd2, 16'h0));
        emit(instr(opc_and, 3'd5, 3'd1, 3'd2, 16'h0));
        emit(instr(opc_or, 3'd6, 3'd1, 3'd2, 16'h0));
        emit(instr(opc_xor, 3'd7, 3'd1, 3'd2, 16'h0));
        // dump r1..r7 from 0x100 up
        for (k = 1; k < 8; k++) begin
            emit(instr(opc_sw, 3'd0, 3'd0, k[2:0], 16'h0100 + 16'(4 * (k - 1))));
            expect_store(32'h100 + 4 * (k - 1), vals[k]);
        end
        emit(instr(opc_halt, 3'd0, 3'd0, 3'd0, 16'h0));
        run_program(rand_en, 16);
    endtask

    task automatic load_store_sums();
        logic [31:0] v0;
        logic [31:0] v1;
        clear_memories();
        v0 = 32'h1357_9bdf;
        v1 = 32'h0246_8ace;
        dmem[8'h80] = v0;
        dmem[8'h81] = v1;
        // base 0x208 with offsets on both sides of it
        emit(instr(opc_addi, 3'd1, 3'd0, 3'd0, 16'h0208));
        emit(instr(opc_lw, 3'd2, 3'd1, 3'd0, 16'hfff8));
        emit(instr(opc_lw, 3'd3, 3'd1, 3'd0, 16'hfffc));
        emit(instr(opc_add, 3'd4, 3'd2, 3'd3, 16'h0));
        emit(instr(opc_sw, 3'd0, 3'd1, 3'd4, 16'h0010));
        emit(instr(opc_lw, 3'd5, 3'd1, 3'd0, 16'h0000));
        emit(instr(opc_sw, 3'd0, 3'd1, 3'd5, 16'hfff0));
        emit(instr(opc_halt, 3'd0, 3'd0, 3'd0, 16'h0));
        expect_store(32'h208 + 32'h10, v0 + v1);
        expect_store(32'h208 - 32'h10, fill_word(32'h208 >> 2));
        run_program(1'b0, 8);
    endtask

    task automatic zero_register();
        clear_memories();
        emit(instr(opc_addi, 3'd0, 3'd0, 3'd0, 16'h0055));
        // r1 shows whether r0 still reads zero
        emit(instr(opc_addi, 3'd1, 3'd0, 3'd0, 16'h0007));
        emit(instr(opc_sw, 3'd0, 3'd0, 3'd0, 16'h0040));
        emit(instr(opc_sw, 3'd0, 3'd0, 3'd1, 16'h0044));
        emit(instr(opc_halt, 3'd0, 3'd0, 3'd0, 16'h0));
        expect_store(32'h40, 32'h0);
        expect_store(32'h44, 32'h7);
        run_program(1'b0, 5);
    endtask

    task automatic halt_and_trap();
        // the store behind an undefined opcode must never issue
        clear_memories();
        emit(instr(opc_addi, 3'd1, 3'd0, 3'd0, 16'h0005));
        emit(instr(opc_sw, 3'd0, 3'd0, 3'd1, 16'h0020));
        emit(32'hf000_0000);
        emit(instr(opc_sw, 3'd0, 3'd0, 3'd1, 16'h0024));
        emit(instr(opc_halt, 3'd0, 3'd0, 3'd0, 16'h0));
        expect_store(32'h20, 32'h5);
        run_program(1'b1, 3);
        // halt with a store after it
        clear_memories();
        emit(instr(opc_addi, 3'd1, 3'd0, 3'd0, 16'h0009));
        emit(instr(opc_sw, 3'd0, 3'd0, 3'd1, 16'h0028));
        emit(instr(opc_halt, 3'd0, 3'd0, 3'd0, 16'h0));
        emit(instr(opc_sw, 3'd0, 3'd0, 3'd1, 16'h002c));
        expect_store(32'h28, 32'h9);
        run_program(1'b1, 3);
    endtask

    initial begin
        resetn = 1'b1;
        iresp = '0;
        dresp = '0;
        ipend = 1'b0;
        dpend = 1'b0;
        icnt = 0;
        dcnt = 0;
        rng = 32'h5020;
        random_delay = 1'b0;
        stop_seen = 1'b0;
        errors = 0;
        cycles = 0;
        prog_len = 0;

        alu_results(1'b0);
        load_store_sums();
        zero_register();
        // same ALU program with random bus delays
        alu_results(1'b1);
        halt_and_trap();

        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/refcpu_pkg.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/mem_access.sv
src/commit.sv
src/refcpu.sv
bench/refcpu_tb.sv

// ==== Bender.yml ====
package:
  name: refcpu

sources:
  - src/refcpu_pkg.sv
  - src/fetch.sv
  - src/decode.sv
  - src/execute.sv
  - src/mem_access.sv
  - src/commit.sv
  - src/refcpu.sv
  - target: test
    files:
      - bench/refcpu_tb.sv
